/* verilog/fifo_defs.svh */
// Build-time configuration of the credit/valid FIFO.
// Include in any file that sizes storage, counters or credit registers.

`ifndef FIFO_DEFS_SVH
`define FIFO_DEFS_SVH

// ---------------------------------------------------------------------------
// Storage geometry
// ---------------------------------------------------------------------------

// Number of RAM slots
`define FIFO_DEPTH 8

// Bits per stored word
`define FIFO_WIDTH 16

// ---------------------------------------------------------------------------
// Flow control
// ---------------------------------------------------------------------------

// Never more credits than free slots
`define FIFO_MAX_CREDIT `FIFO_DEPTH

`endif

/* verilog/credit_pkg.sv */
// Flow-control types shared by the credit receiver, the top level
// and the testbench.

`default_nettype none

`include "fifo_defs.svh"

package credit_pkg;

  // Enough bits to hold 0 up to the max credit, inclusive
  localparam int CREDIT_W = $clog2(`FIFO_MAX_CREDIT + 1);

  // Credit count
  typedef logic [CREDIT_W-1:0] credit_t;

endpackage : credit_pkg

`default_nettype wire

/* verilog/fifo_pkg.sv */
// Storage types and pop FSM encoding for the FIFO.
// Imported by the RAM, both controllers, the RAM interface and the top.

`default_nettype none

`include "fifo_defs.svh"

package fifo_pkg;

  // Address and count widths derived from depth
  localparam int FIFO_ADDR_W  = $clog2(`FIFO_DEPTH);
  localparam int FIFO_COUNT_W = $clog2(`FIFO_DEPTH + 1);

  // One stored word
  typedef logic [`FIFO_WIDTH-1:0] fifo_data_t;

  // RAM address
  typedef logic [FIFO_ADDR_W-1:0] fifo_addr_t;

  // Slot or item count, 0 to depth
  typedef logic [FIFO_COUNT_W-1:0] fifo_count_t;

  // Four-phase pop handshake states
  typedef enum logic [1:0] {
    IDLE,
    REQ,
    RELEASE
  } pop_state_e;

endpackage : fifo_pkg

`default_nettype wire

/* verilog/fifo_ram_if.sv */
// Write and read ports of the FIFO storage.
// Push controller writes, pop controller reads, RAM sits behind mem.

`timescale 1ns/100ps
`default_nettype none

interface fifo_ram_if
  import fifo_pkg::*;
();

  // Write port
  logic       wr_valid;
  fifo_addr_t wr_addr;
  fifo_data_t wr_data;

  // Read port, combinational data
  fifo_addr_t rd_addr;
  fifo_data_t rd_data;

  modport writer (output wr_valid, output wr_addr, output wr_data);

  modport reader (output rd_addr, input rd_data);

  modport mem (
    input  wr_valid,
    input  wr_addr,
    input  wr_data,
    input  rd_addr,
    output rd_data
  );

endinterface : fifo_ram_if

`default_nettype wire

/* verilog/credit_receiver.sv */
// Credit receiver for the push side of the FIFO.
// Hands out one credit per cycle to the producer and takes back one per pop.
// Pushes pass straight through; the producer is trusted to hold a credit.

`timescale 1ns/100ps
`default_nettype none

module credit_receiver
  import credit_pkg::*;
  import fifo_pkg::*;
(
  input  wire        clk,
  input  wire        reset,

  // Producer side
  input  wire        push_credit_stall,
  output logic       push_credit,
  input  wire        push_valid,
  input  fifo_data_t push_data,

  // Returned credit, one per completed pop
  input  wire        pop_credit,

  // Toward the push controller
  output logic       internal_valid,
  output fifo_data_t internal_data,

  // Credit configuration and status
  input  credit_t    credit_initial,
  input  credit_t    credit_withhold,
  output credit_t    credit_count,
  output credit_t    credit_available
);

  // ---------------------------------------------------------------------------
  // Credit accounting
  // ---------------------------------------------------------------------------

  logic issue;

  // Credits above the withheld amount can be given out
  assign credit_available = (credit_count > credit_withhold) ?
                            credit_t'(credit_count - credit_withhold) : '0;

  // At most one credit per cycle
  assign issue = !push_credit_stall && (credit_available != '0);

  // Count of credits still held here; push_credit is the registered issue
  always_ff @(posedge clk) begin
    if (reset) begin
      credit_count <= credit_initial;
      push_credit  <= 1'b0;
    end else begin
      push_credit <= issue;
      if (pop_credit && !issue) begin
        credit_count <= credit_count + 1'b1;
      end else if (!pop_credit && issue) begin
        credit_count <= credit_count - 1'b1;
      end
    end
  end

  // ---------------------------------------------------------------------------
  // Push forwarding
  // ---------------------------------------------------------------------------

  // Every push is backed by a credit, so it is always accepted
  assign internal_valid = push_valid;
  assign internal_data  = push_data;

endmodule : credit_receiver

`default_nettype wire

/* verilog/fifo_push_ctrl_credit.sv */
// Push controller of the FIFO.
// Writes each accepted word into the RAM and tracks free slots and full.

`timescale 1ns/100ps
`default_nettype none

`include "fifo_defs.svh"

module fifo_push_ctrl_credit
  import fifo_pkg::*;
(
  input  wire         clk,
  input  wire         reset,

  // From the credit receiver
  input  wire         internal_valid,
  input  fifo_data_t  internal_data,

  // RAM write port
  fifo_ram_if.writer  ram,

  // Handshakes with the pop controller
  output logic        ram_push,
  input  wire         ram_pop,

  // Status
  output logic        full,
  output fifo_count_t slots
);

  fifo_addr_t  wr_addr;
  fifo_count_t slots_next;

  // ---------------------------------------------------------------------------
  // Write path
  // ---------------------------------------------------------------------------

  // No bypass, so every accepted word goes to the RAM
  assign ram_push     = internal_valid;
  assign ram.wr_valid = ram_push;
  assign ram.wr_addr  = wr_addr;
  assign ram.wr_data  = internal_data;

  // Wrapping write pointer
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_addr <= '0;
    end else if (ram_push) begin
      if (wr_addr == fifo_addr_t'(`FIFO_DEPTH - 1)) begin
        wr_addr <= '0;
      end else begin
        wr_addr <= wr_addr + 1'b1;
      end
    end
  end

  // ---------------------------------------------------------------------------
  // Slot count and full flag
  // ---------------------------------------------------------------------------

  // Push and pop in one cycle cancel out
  always_comb begin
    slots_next = slots;
    if (ram_push && !ram_pop) begin
      slots_next = slots - 1'b1;
    end else if (!ram_push && ram_pop) begin
      slots_next = slots + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      slots <= fifo_count_t'(`FIFO_DEPTH);
      full  <= 1'b0;
    end else if (ram_push || ram_pop) begin
      slots <= slots_next;
      full  <= (slots_next == '0);
    end
  end

endmodule : fifo_push_ctrl_credit

`default_nettype wire

/* verilog/fifo_pop_ctrl_req_ack.sv */
// Pop controller of the FIFO.
// Presents the oldest word over a four-phase req/ack handshake and
// reports each completed pop to the push side as a one-cycle pulse.

`timescale 1ns/100ps
`default_nettype none

`include "fifo_defs.svh"

module fifo_pop_ctrl_req_ack
  import fifo_pkg::*;
(
  input  wire         clk,
  input  wire         reset,

  // RAM read port
  fifo_ram_if.reader  ram,

  // Handshakes with the push controller
  input  wire         ram_push,
  output logic        ram_pop,

  // Consumer side
  output logic        pop_req,
  input  wire         pop_ack,
  output fifo_data_t  pop_data,

  // Status
  output fifo_count_t items
);

  pop_state_e state;
  pop_state_e state_next;
  fifo_addr_t rd_addr;

  // ---------------------------------------------------------------------------
  // Pop FSM
  // ---------------------------------------------------------------------------

  always_comb begin
    state_next = state;
    unique case (state)
      // Wait for a stored word
      IDLE:    if (items != '0) state_next = REQ;
      // Hold req and data until ack
      REQ:     if (pop_ack) state_next = RELEASE;
      // Wait for ack to drop before another req
      RELEASE: if (!pop_ack) state_next = IDLE;
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= IDLE;
      ram_pop <= 1'b0;
    end else begin
      state   <= state_next;
      // Word counts as popped in the cycle req drops
      ram_pop <= (state == REQ) && pop_ack;
    end
  end

  assign pop_req = (state == REQ);

  // ---------------------------------------------------------------------------
  // Read path and item count
  // ---------------------------------------------------------------------------

  assign ram.rd_addr = rd_addr;
  assign pop_data    = ram.rd_data;

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_addr <= '0;
      items   <= '0;
    end else begin
      // Advance only once a pop has completed
      if (ram_pop) begin
        if (rd_addr == fifo_addr_t'(`FIFO_DEPTH - 1)) begin
          rd_addr <= '0;
        end else begin
          rd_addr <= rd_addr + 1'b1;
        end
      end
      if (ram_push && !ram_pop) begin
        items <= items + 1'b1;
      end else if (!ram_push && ram_pop) begin
        items <= items - 1'b1;
      end
    end
  end

endmodule : fifo_pop_ctrl_req_ack

`default_nettype wire

/* verilog/fifo_flop_ram.sv */
// Flop-based FIFO storage.
// One synchronous write port and one combinational read port.

`timescale 1ns/100ps
`default_nettype none

`include "fifo_defs.svh"

module fifo_flop_ram
  import fifo_pkg::*;
(
  input wire       clk,
  fifo_ram_if.mem  ram
);

  // Depth-by-width register array
  fifo_data_t mem_q [`FIFO_DEPTH];

  // Write on the clock edge
  always_ff @(posedge clk) begin
    if (ram.wr_valid) begin
      mem_q[ram.wr_addr] <= ram.wr_data;
    end
  end

  // Read data follows the address in the same cycle
  assign ram.rd_data = mem_q[ram.rd_addr];

endmodule : fifo_flop_ram

`default_nettype wire

/* verilog/fifo_credit_top.sv */
// Top level of the credit/valid FIFO with a req/ack pop side.
// Connects the credit receiver, both controllers and the RAM.

`timescale 1ns/100ps
`default_nettype none

module fifo_credit_top
  import credit_pkg::*;
  import fifo_pkg::*;
(
  input  wire         clk,
  input  wire         reset,

  // Push side
  input  wire         push_credit_stall,
  output logic        push_credit,
  input  wire         push_valid,
  input  fifo_data_t  push_data,

  // Credit configuration and status
  input  credit_t     credit_initial,
  input  credit_t     credit_withhold,
  output credit_t     credit_count,
  output credit_t     credit_available,

  // Occupancy
  output logic        full,
  output fifo_count_t slots,
  output fifo_count_t items,

  // Pop side
  output logic        pop_req,
  input  wire         pop_ack,
  output fifo_data_t  pop_data
);

  logic       internal_valid;
  fifo_data_t internal_data;
  logic       ram_push;
  logic       ram_pop;

  fifo_ram_if ram_if ();

  // ---------------------------------------------------------------------------
  // Push side
  // ---------------------------------------------------------------------------

  credit_receiver u_credit_receiver (
    .clk               (clk),
    .reset             (reset),
    .push_credit_stall (push_credit_stall),
    .push_credit       (push_credit),
    .push_valid        (push_valid),
    .push_data         (push_data),
    .pop_credit        (ram_pop),
    .internal_valid    (internal_valid),
    .internal_data     (internal_data),
    .credit_initial    (credit_initial),
    .credit_withhold   (credit_withhold),
    .credit_count      (credit_count),
    .credit_available  (credit_available)
  );

  fifo_push_ctrl_credit u_push_ctrl (
    .clk            (clk),
    .reset          (reset),
    .internal_valid (internal_valid),
    .internal_data  (internal_data),
    .ram            (ram_if.writer),
    .ram_push       (ram_push),
    .ram_pop        (ram_pop),
    .full           (full),
    .slots          (slots)
  );

  // ---------------------------------------------------------------------------
  // Storage and pop side
  // ---------------------------------------------------------------------------

  fifo_flop_ram u_ram (
    .clk (clk),
    .ram (ram_if.mem)
  );

  fifo_pop_ctrl_req_ack u_pop_ctrl (
    .clk      (clk),
    .reset    (reset),
    .ram      (ram_if.reader),
    .ram_push (ram_push),
    .ram_pop  (ram_pop),
    .pop_req  (pop_req),
    .pop_ack  (pop_ack),
    .pop_data (pop_data),
    .items    (items)
  );

endmodule : fifo_credit_top

`default_nettype wire

/* verification/fifo_credit_props.sv */
// Handshake assertions for the credit/valid FIFO.
// Bound into the top level, checks the producer and consumer protocols.

`timescale 1ns/100ps
`default_nettype none

module fifo_credit_props
  import fifo_pkg::*;
(
  input wire        clk,
  input wire        reset,
  input wire        push_credit,
  input wire        push_valid,
  input wire        pop_req,
  input wire        pop_ack,
  input fifo_data_t pop_data
);

  // Credits handed out and not yet spent
  int unsigned unspent;

  always_ff @(posedge clk) begin
    if (reset) begin
      unspent <= 0;
    end else if (push_credit && !push_valid) begin
      unspent <= unspent + 1;
    end else if (!push_credit && push_valid) begin
      unspent <= unspent - 1;
    end
  end

  // Every push backed by an earlier credit
  a_push_has_credit : assert property (@(posedge clk) disable iff (reset)
    push_valid |-> unspent != 0)
    else $error("push_valid without an unspent credit");

  // Word held steady for the whole request
  a_pop_data_stable : assert property (@(posedge clk) disable iff (reset)
    pop_req && $past(pop_req) |-> $stable(pop_data))
    else $error("pop_data changed while pop_req was high");

  // Request drops only in answer to ack
  a_req_falls_on_ack : assert property (@(posedge clk) disable iff (reset)
    $fell(pop_req) |-> $past(pop_ack))
    else $error("pop_req fell without pop_ack");

endmodule : fifo_credit_props

bind fifo_credit_top fifo_credit_props u_props (
  .clk         (clk),
  .reset       (reset),
  .push_credit (push_credit),
  .push_valid  (push_valid),
  .pop_req     (pop_req),
  .pop_ack     (pop_ack),
  .pop_data    (pop_data)
);

`default_nettype wire

/* verification/tb_fifo_credit.sv */
// Testbench for the credit/valid FIFO with a req/ack pop side.
// Reads tests from the golden file, models the producer and the consumer,
// and checks data order, occupancy and credit accounting.

`timescale 1ns/100ps
`default_nettype none

`include "fifo_defs.svh"

// Free-running 10 ns clock
module tb_clock_gen (
  output logic clk
);
  initial clk = 1'b0;
  always #5 clk = ~clk;
endmodule : tb_clock_gen

module tb_fifo_credit
  import credit_pkg::*;
  import fifo_pkg::*;
();

  localparam int MAX_TESTS    = 8;
  localparam int MAX_WORDS    = 12;
  localparam int RESET_CYCLES = 16;
  localparam int QUIET_CYCLES = 20;
  localparam int SETTLE       = 10;

  logic        clk;
  logic        reset;
  logic        push_credit_stall;
  logic        push_credit;
  logic        push_valid;
  fifo_data_t  push_data;
  credit_t     credit_initial;
  credit_t     credit_withhold;
  credit_t     credit_count;
  credit_t     credit_available;
  logic        full;
  fifo_count_t slots;
  fifo_count_t items;
  logic        pop_req;
  logic        pop_ack;
  fifo_data_t  pop_data;

  // Tests as read from the golden file
  string       test_name [MAX_TESTS];
  credit_t     t_init [MAX_TESTS];
  credit_t     t_withhold [MAX_TESTS];
  logic        t_stall [MAX_TESTS];
  logic        t_hold [MAX_TESTS];
  int          t_len [MAX_TESTS];
  fifo_data_t  t_words [MAX_TESTS][MAX_WORDS];
  int          num_tests;
  int          total_words;
  int          cycle_limit;

  // Producer and consumer model state
  int          cur;
  int          held;
  int          credits_rcvd;
  int          pushed;
  int          popped;
  int          ack_delay;
  logic        push_en;
  logic        hold_pop;
  logic [31:0] lcg_state;
  int          checks;
  int          errors;

  tb_clock_gen u_clk (.clk(clk));

  fifo_credit_top dut0 (
    .clk               (clk),
    .reset             (reset),
    .push_credit_stall (push_credit_stall),
    .push_credit       (push_credit),
    .push_valid        (push_valid),
    .push_data         (push_data),
    .credit_initial    (credit_initial),
    .credit_withhold   (credit_withhold),
    .credit_count      (credit_count),
    .credit_available  (credit_available),
    .full              (full),
    .slots             (slots),
    .items             (items),
    .pop_req           (pop_req),
    .pop_ack           (pop_ack),
    .pop_data          (pop_data)
  );

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------

  // Ack delay of 0 to 3 cycles
  function automatic int lcg_delay();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return int'(lcg_state[30:16] % 4);
  endfunction

  task automatic report_error(input string msg);
    errors++;
    $display("ERROR: %s", msg);
  endtask

  task automatic check_data(input string tname, input fifo_data_t exp, input fifo_data_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", tname, exp, act);
    end
  endtask

  task automatic check_count(input string tname, input credit_t exp, input credit_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s: expected %0d, actual %0d", tname, exp, act);
    end
  endtask

  task automatic check_slots(input string tname, input fifo_count_t exp,
                             input fifo_count_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s: expected %0d, actual %0d", tname, exp, act);
    end
  endtask

  task automatic check_flag(input string tname, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s: expected %b, actual %b", tname, exp, act);
    end
  endtask

  // One clock of both models; outputs read here are the pre-edge values
  task automatic step_cycle();
    @(posedge clk);
    // Producer spends a credit per push
    if (push_credit) begin
      held++;
      credits_rcvd++;
    end
    if (push_en && held > 0 && pushed < t_len[cur]) begin
      push_valid <= 1'b1;
      push_data  <= t_words[cur][pushed];
      held--;
      pushed++;
    end else begin
      push_valid <= 1'b0;
    end
    // Consumer, four-phase ack
    if (pop_ack && !pop_req) begin
      pop_ack <= 1'b0;
    end else if (!pop_ack && pop_req && !hold_pop) begin
      if (ack_delay > 0) begin
        ack_delay--;
      end else begin
        pop_ack <= 1'b1;
        if (popped < t_len[cur]) begin
          check_data({test_name[cur], " pop order"}, t_words[cur][popped], pop_data);
        end else begin
          report_error({test_name[cur], ": more words popped than were pushed"});
        end
        popped++;
        ack_delay = lcg_delay();
      end
    end
    // Free slots and stored items always cover the whole depth
    if (!push_valid && !reset) begin
      check_slots({test_name[cur], " slot sum"},
                  fifo_count_t'(`FIFO_DEPTH) - items, slots);
    end
  endtask

  // --------------------------------------------------------------------------
  // One golden test
  // --------------------------------------------------------------------------

  task automatic run_test(input int i);
    cur      = i;
    push_en  = 1'b0;
    hold_pop = 1'b0;
    push_credit_stall <= t_stall[i];
    credit_initial    <= t_init[i];
    credit_withhold   <= t_withhold[i];
    push_valid        <= 1'b0;
    pop_ack           <= 1'b0;
    reset             <= 1'b1;
    repeat (RESET_CYCLES) step_cycle();
    reset <= 1'b0;
    held         = 0;
    credits_rcvd = 0;
    pushed       = 0;
    popped       = 0;
    ack_delay    = lcg_delay();

    // Stall keeps every credit in the receiver
    if (t_stall[i]) begin
      repeat (QUIET_CYCLES) step_cycle();
      check_count({test_name[i], " credits in stall"}, '0, credit_t'(credits_rcvd));
      check_count({test_name[i], " count in stall"}, t_init[i], credit_count);
      check_count({test_name[i], " available in stall"},
                  credit_t'(t_init[i] - t_withhold[i]), credit_available);
      push_credit_stall <= 1'b0;
    end

    // Idle producer collects initial minus withhold
    repeat (QUIET_CYCLES) step_cycle();
    check_count({test_name[i], " issued credits"}, credit_t'(t_init[i] - t_withhold[i]),
                credit_t'(credits_rcvd));
    check_count({test_name[i], " retained credits"}, t_withhold[i], credit_count);
    check_count({test_name[i], " available credits"}, '0, credit_available);

    push_en  = 1'b1;
    hold_pop = t_hold[i];
    if (hold_pop) begin
      while (pushed < `FIFO_DEPTH) step_cycle();
      repeat (8) step_cycle();
      check_flag({test_name[i], " full"}, 1'b1, full);
      check_slots({test_name[i], " slots when full"}, '0, slots);
      check_slots({test_name[i], " items when full"}, fifo_count_t'(`FIFO_DEPTH), items);
      check_count({test_name[i], " credits while full"},
                  credit_t'(t_init[i] - t_withhold[i]), credit_t'(credits_rcvd));
      hold_pop = 1'b0;
    end
    while (popped < t_len[i]) step_cycle();
    repeat (SETTLE) step_cycle();

    // Drained and idle
    check_flag({test_name[i], " full idle"}, 1'b0, full);
    check_slots({test_name[i], " items idle"}, '0, items);
    check_slots({test_name[i], " slots idle"}, fifo_count_t'(`FIFO_DEPTH), slots);
    check_count({test_name[i], " credit total"}, t_init[i],
                credit_t'(held + credit_count + items));
    push_en = 1'b0;
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------

  initial begin
    int                fd;
    int                n;
    int                init_v;
    int                withhold_v;
    int                stall_v;
    int                hold_v;
    int                len_v;
    logic [8*160-1:0]  line;
    logic [8*16-1:0]   nm;
    reset             = 1'b1;
    push_credit_stall = 1'b0;
    push_valid        = 1'b0;
    push_data         = '0;
    credit_initial    = '0;
    credit_withhold   = '0;
    pop_ack           = 1'b0;
    push_en           = 1'b0;
    hold_pop          = 1'b0;
    cur               = 0;
    lcg_state         = 32'd92377;
    checks            = 0;
    errors            = 0;
    num_tests         = 0;
    total_words       = 0;
    cycle_limit       = 0;

    fd = $fopen("verification/fifo_credit_golden.txt", "r");
    if (fd == 0) begin
      report_error("cannot open the golden file");
    end else begin
      while ($fgets(line, fd) != 0) begin
        n = $sscanf(line, "%s %d %d %d %d %d %h %h %h %h %h %h %h %h %h %h %h %h",
                    nm, init_v, withhold_v, stall_v, hold_v, len_v,
                    t_words[num_tests][0], t_words[num_tests][1], t_words[num_tests][2],
                    t_words[num_tests][3], t_words[num_tests][4], t_words[num_tests][5],
                    t_words[num_tests][6], t_words[num_tests][7], t_words[num_tests][8],
                    t_words[num_tests][9], t_words[num_tests][10],
                    t_words[num_tests][11]);
        if (n == 18 && num_tests < MAX_TESTS && len_v <= MAX_WORDS) begin
          test_name[num_tests]  = $sformatf("%0s", nm);
          t_init[num_tests]     = credit_t'(init_v);
          t_withhold[num_tests] = credit_t'(withhold_v);
          t_stall[num_tests]    = (stall_v != 0);
          t_hold[num_tests]     = (hold_v != 0);
          t_len[num_tests]      = len_v;
          total_words += len_v;
          num_tests++;
        end else if (n > 1) begin
          report_error("malformed line in the golden file");
        end
      end
      $fclose(fd);
    end

    // Twenty cycles per word plus every reset
    cycle_limit = 20 * total_words + RESET_CYCLES * num_tests;

    for (int k = 0; k < num_tests; k++) begin
      run_test(k);
    end

    $display("Summary: %0d tests, %0d checks, %0d errors", num_tests, checks, errors);
    if (errors == 0 && num_tests > 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Cycle counter against a hung handshake
  initial begin
    int cycles;
    cycles = 0;
    wait (cycle_limit != 0);
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("ERROR: run did not finish within %0d cycles", cycle_limit);
    $display("Summary: %0d tests, %0d checks, %0d errors", num_tests, checks, errors + 1);
    $display("Test failed");
    $finish;
  end

endmodule : tb_fifo_credit

`default_nettype wire

/* verification/fifo_credit_golden.txt */
# name initial withhold stall hold count, then 12 data words in hex
# words past count are padding and are never pushed; pop order equals push order
basic      8 0 0 0 12 1234 abcd 0001 8000 ffff 5a5a a5a5 0f0f f0f0 7e81 3c3c c3c3
withhold   8 3 0 0 10 0010 0020 0030 0040 0050 0060 0070 0080 0090 00a0 0000 0000
stalled    6 0 1 0  9 dead beef cafe f00d 1357 2468 9bdf ace0 4242 0000 0000 0000
full_hold  8 0 0 1 12 a001 a002 a003 a004 a005 a006 a007 a008 a009 a00a a00b a00c
one_credit 2 1 0 0  6 7fff 8001 0000 ffff 5555 aaaa 0000 0000 0000 0000 0000 0000

/* sim.f */
+incdir+verilog
verilog/credit_pkg.sv
verilog/fifo_pkg.sv
verilog/fifo_ram_if.sv
verilog/credit_receiver.sv
verilog/fifo_push_ctrl_credit.sv
verilog/fifo_pop_ctrl_req_ack.sv
verilog/fifo_flop_ram.sv
verilog/fifo_credit_top.sv
verification/fifo_credit_props.sv
verification/tb_fifo_credit.sv

/* Makefile */
# Verilator build, run, lint and clean for the credit FIFO testbench

TOP = tb_fifo_credit

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	  echo "$$out" | grep -qx 'Test passed'

lint:
	verilator --lint-only -Wall --timing -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir
